//--- design/bridge_pkg.sv
`default_nettype none
//------------------------------
// bridge shared definitions
// byte and port types, rx trim sizes, tx feeder states
//------------------------------
package bridge_pkg;

    //------------------------------
    // widths
    //------------------------------
    localparam int MAX_PORTS = 4;                // upper limit for ETH_COUNT

    // one frame byte as it moves through mac, fifo and link
    typedef logic [7:0] byte_t;

    // index of the active port, sized for MAX_PORTS
    typedef logic [$clog2(MAX_PORTS)-1:0] port_sel_t;

    //------------------------------
    // rx frame trimming
    //------------------------------
    localparam int HDR_SKIP_BYTES = 8;           // preamble + sfd
    localparam int FCS_BYTES      = 4;           // crc32 tail

    // den history needed to decide whether a delayed byte is payload
    localparam int DEN_DEPTH = HDR_SKIP_BYTES + FCS_BYTES;

    //------------------------------
    // tx feeder
    //------------------------------
    typedef enum logic [1:0] {
        FEED_IDLE,                               // no complete frame yet
        FEED_REQ,                                // rq up, waiting for grant
        FEED_SEND                                // one pop per cycle
    } feeder_state_t;

endpackage

`default_nettype wire

//--- design/rx_payload_strip.sv
`timescale 1ns/1ps
`default_nettype none
//------------------------------
// rx payload stripper
// drops leading header and trailing fcs bytes of each mac frame
//------------------------------
module rx_payload_strip (
    input  wire                     clk125M,
    input  wire                     rst_n_i,

    input  wire bridge_pkg::byte_t  rx_data_i,
    input  wire                     rx_den_i,
    input  wire                     rx_eof_i,

    output bridge_pkg::byte_t       pl_data_o,
    output logic                    pl_valid_o,
    output logic                    pl_last_o
);

    localparam int DEPTH = bridge_pkg::DEN_DEPTH;
    localparam int DLY   = bridge_pkg::FCS_BYTES;

    bridge_pkg::byte_t      data_sr [DLY];      // data delay line, [DLY-1] oldest
    logic [DEPTH-1:0]       den_sr;             // den history, msb oldest
    logic                   in_window;

    // delayed byte is payload once HDR_SKIP_BYTES bytes lie behind it
    // and the current byte is still in the frame, so the fcs is cut off.
    // the full window must be high, which also rejects a short frame
    // that follows a long one closely
    assign in_window = (&den_sr) & rx_den_i;

    //------------------------------
    // data path
    //------------------------------
    always_ff @(posedge clk125M) begin
        data_sr[0] <= rx_data_i;
        for (int k = 1; k < DLY; k++) begin
            data_sr[k] <= data_sr[k-1];
        end
        pl_data_o <= data_sr[DLY-1];            // last payload byte when eof arrives
    end

    //------------------------------
    // valid / last
    //------------------------------
    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            den_sr     <= '0;
            pl_valid_o <= 1'b0;
            pl_last_o  <= 1'b0;
        end else begin
            den_sr     <= {den_sr[DEPTH-2:0], rx_den_i};
            pl_valid_o <= in_window;
            pl_last_o  <= in_window & rx_eof_i; // eof lines up with last payload byte
        end
    end

endmodule

`default_nettype wire

//--- design/tx_frame_fifo.sv
`timescale 1ns/1ps
`default_nettype none
//------------------------------
// tx frame fifo
// byte + end flag storage per port, counts complete frames held
//------------------------------
module tx_frame_fifo #(
    parameter int FIFO_AW = 6                   // 2**FIFO_AW entries
) (
    input  wire                     clk125M,
    input  wire                     rst_n_i,
    input  wire                     flush_i,    // port disabled, hold empty

    input  wire                     wr_en_i,
    input  wire bridge_pkg::byte_t  wr_data_i,
    input  wire                     wr_last_i,

    input  wire                     rd_en_i,
    output bridge_pkg::byte_t       rd_data_o,
    output logic                    rd_last_o,
    output logic                    frame_avail_o
);

    localparam int DEPTH = 2 ** FIFO_AW;

    logic [8:0]             mem [DEPTH];        // {end flag, byte}
    logic [FIFO_AW:0]       wr_ptr;             // extra msb tells full from empty
    logic [FIFO_AW:0]       rd_ptr;
    logic [FIFO_AW:0]       frame_cnt;          // complete frames stored
    logic                   full;
    logic                   empty;
    logic                   wr_ok;
    logic                   rd_ok;

    assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                   (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign wr_ok = wr_en_i & ~full;             // byte dropped when full
    assign rd_ok = rd_en_i & ~empty;

    // head entry shown ahead of the pop
    assign rd_data_o = mem[rd_ptr[FIFO_AW-1:0]][7:0];
    assign rd_last_o = mem[rd_ptr[FIFO_AW-1:0]][8];

    assign frame_avail_o = (frame_cnt != '0);

    //------------------------------
    // storage
    //------------------------------
    always_ff @(posedge clk125M) begin
        if (wr_ok) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= {wr_last_i, wr_data_i};
        end
    end

    //------------------------------
    // pointers and frame count
    //------------------------------
    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            frame_cnt <= '0;
        end else if (flush_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            frame_cnt <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // frame in on written end flag, out on popped end flag
            case ({wr_ok & wr_last_i, rd_ok & rd_last_o})
                2'b10:   frame_cnt <= frame_cnt + 1'b1;
                2'b01:   frame_cnt <= frame_cnt - 1'b1;
                default: frame_cnt <= frame_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/mac_tx_feeder.sv
`timescale 1ns/1ps
`default_nettype none
//------------------------------
// mac tx feeder
// asks the mac for the medium and drains one frame per grant
//------------------------------
module mac_tx_feeder (
    input  wire                     clk125M,
    input  wire                     rst_n_i,

    // fifo side
    input  wire                     frame_avail_i,
    input  wire bridge_pkg::byte_t  rd_data_i,
    input  wire                     rd_last_i,
    output logic                    rd_en_o,

    // mac side
    input  wire                     mac_tx_ack_i,
    output logic                    mac_tx_rq_o,
    output bridge_pkg::byte_t       mac_tx_data_o,
    output logic                    mac_tx_val_o,
    output logic                    mac_tx_sof_o,
    output logic                    mac_tx_eof_o
);

    bridge_pkg::feeder_state_t  state;
    logic                       rd_en_q;        // pop of previous cycle

    // frame_avail stays up until the end byte is popped,
    // low here only when the fifo got flushed
    assign rd_en_o = (state == bridge_pkg::FEED_SEND) & frame_avail_i;

    //------------------------------
    // request / grant fsm
    //------------------------------
    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state       <= bridge_pkg::FEED_IDLE;
            mac_tx_rq_o <= 1'b0;
        end else begin
            case (state)
                bridge_pkg::FEED_IDLE: begin
                    if (frame_avail_i) begin
                        state       <= bridge_pkg::FEED_REQ;
                        mac_tx_rq_o <= 1'b1;
                    end
                end
                bridge_pkg::FEED_REQ: begin
                    if (!frame_avail_i) begin       // flushed while waiting
                        state       <= bridge_pkg::FEED_IDLE;
                        mac_tx_rq_o <= 1'b0;
                    end else if (mac_tx_ack_i) begin
                        state <= bridge_pkg::FEED_SEND;
                    end
                end
                bridge_pkg::FEED_SEND: begin
                    if (!frame_avail_i || rd_last_i) begin
                        state       <= bridge_pkg::FEED_IDLE;
                        mac_tx_rq_o <= 1'b0;        // drops after last pop
                    end
                end
                default: begin
                    state       <= bridge_pkg::FEED_IDLE;
                    mac_tx_rq_o <= 1'b0;
                end
            endcase
        end
    end

    //------------------------------
    // mac strobes, one cycle behind the pop
    //------------------------------
    always_ff @(posedge clk125M) begin
        mac_tx_data_o <= rd_data_i;
    end

    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_en_q      <= 1'b0;
            mac_tx_val_o <= 1'b0;
            mac_tx_sof_o <= 1'b0;
            mac_tx_eof_o <= 1'b0;
        end else begin
            rd_en_q      <= rd_en_o;
            mac_tx_val_o <= rd_en_o;
            mac_tx_sof_o <= rd_en_o & ~rd_en_q;     // first pop of the frame
            mac_tx_eof_o <= rd_en_o & rd_last_i;
        end
    end

endmodule

`default_nettype wire

//--- design/port_select.sv
`timescale 1ns/1ps
`default_nettype none
//------------------------------
// port selector
// link tx mux from the active port, link rx steered to its fifo
//------------------------------
module port_select #(
    parameter int ETH_COUNT = 4
) (
    input  wire                         clk125M,
    input  wire                         rst_n_i,

    input  wire                         module_en_i,
    input  wire bridge_pkg::port_sel_t  eth_num_i,
    input  wire                         link_channel_up_i,
    input  wire [ETH_COUNT-1:0]         mac_link_up_i,

    // stripped rx payload of every port
    input  wire [ETH_COUNT*8-1:0]       pl_data_i,
    input  wire [ETH_COUNT-1:0]         pl_valid_i,
    input  wire [ETH_COUNT-1:0]         pl_last_i,

    // link rx
    input  wire bridge_pkg::byte_t      link_rx_data_i,
    input  wire                         link_rx_valid_i,
    input  wire                         link_rx_last_i,

    // fifo write side
    output logic [ETH_COUNT-1:0]        wr_en_o,
    output bridge_pkg::byte_t           wr_data_o,
    output logic                        wr_last_o,
    output logic [ETH_COUNT-1:0]        flush_o,

    // link tx
    output bridge_pkg::byte_t           link_tx_data_o,
    output logic                        link_tx_valid_o,
    output logic                        link_tx_last_o
);

    logic [ETH_COUNT-1:0]   port_en;
    logic                   sel_ok;             // module on, selected port exists

    //------------------------------
    // link rx -> fifo
    //------------------------------
    always_comb begin
        for (int i = 0; i < ETH_COUNT; i++) begin
            port_en[i] = module_en_i && (int'(eth_num_i) == i) &&
                         mac_link_up_i[i] && link_channel_up_i;
        end
    end

    assign flush_o   = ~port_en;                // idle ports keep their fifo empty
    assign wr_en_o   = port_en & {ETH_COUNT{link_rx_valid_i}};
    assign wr_data_o = link_rx_data_i;          // shared, wr_en picks the port
    assign wr_last_o = link_rx_last_i;

    //------------------------------
    // rx payload -> link tx
    //------------------------------
    assign sel_ok = module_en_i && (int'(eth_num_i) < ETH_COUNT);

    always_ff @(posedge clk125M) begin
        if (sel_ok) begin
            link_tx_data_o <= pl_data_i[eth_num_i*8 +: 8];
        end
    end

    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            link_tx_valid_o <= 1'b0;
            link_tx_last_o  <= 1'b0;
        end else begin
            link_tx_valid_o <= sel_ok && pl_valid_i[eth_num_i];
            link_tx_last_o  <= sel_ok && pl_valid_i[eth_num_i] && pl_last_i[eth_num_i];
        end
    end

endmodule

`default_nettype wire

//--- design/eth_port_bridge.sv
`timescale 1ns/1ps
`default_nettype none
//------------------------------
// ethernet port bridge
// per-port rx strip and tx fifo/feeder joined to one serial link
//------------------------------
module eth_port_bridge #(
    parameter int ETH_COUNT = 4,                // 1 .. MAX_PORTS
    parameter int FIFO_AW   = 6                 // 64 bytes per port
) (
    input  wire                         clk125M,
    input  wire                         rst_n_i,

    input  wire                         module_en_i,
    input  wire bridge_pkg::port_sel_t  eth_num_i,
    input  wire                         link_channel_up_i,

    // mac rx
    input  wire [ETH_COUNT-1:0]         mac_link_up_i,
    input  wire [ETH_COUNT*8-1:0]       mac_rx_data_i,
    input  wire [ETH_COUNT-1:0]         mac_rx_den_i,
    input  wire [ETH_COUNT-1:0]         mac_rx_eof_i,

    // mac tx
    input  wire [ETH_COUNT-1:0]         mac_tx_ack_i,
    output logic [ETH_COUNT-1:0]        mac_tx_rq_o,
    output logic [ETH_COUNT*8-1:0]      mac_tx_data_o,
    output logic [ETH_COUNT-1:0]        mac_tx_val_o,
    output logic [ETH_COUNT-1:0]        mac_tx_sof_o,
    output logic [ETH_COUNT-1:0]        mac_tx_eof_o,

    // serial link
    input  wire bridge_pkg::byte_t      link_rx_data_i,
    input  wire                         link_rx_valid_i,
    input  wire                         link_rx_last_i,
    output bridge_pkg::byte_t           link_tx_data_o,
    output logic                        link_tx_valid_o,
    output logic                        link_tx_last_o
);

    // stripper -> selector
    wire [ETH_COUNT*8-1:0]      pl_data;
    wire [ETH_COUNT-1:0]        pl_valid;
    wire [ETH_COUNT-1:0]        pl_last;

    // selector -> fifo
    wire [ETH_COUNT-1:0]        wr_en;
    wire bridge_pkg::byte_t     wr_data;
    wire                        wr_last;
    wire [ETH_COUNT-1:0]        flush;

    // fifo <-> feeder
    wire [ETH_COUNT-1:0]        rd_en;
    wire [ETH_COUNT*8-1:0]      rd_data;
    wire [ETH_COUNT-1:0]        rd_last;
    wire [ETH_COUNT-1:0]        frame_avail;

    //------------------------------
    // per-port lanes
    //------------------------------
    for (genvar x = 0; x < ETH_COUNT; x++) begin : eth
        rx_payload_strip strip_inst (
            .clk125M    (clk125M),
            .rst_n_i    (rst_n_i),
            .rx_data_i  (mac_rx_data_i[x*8 +: 8]),
            .rx_den_i   (mac_rx_den_i[x]),
            .rx_eof_i   (mac_rx_eof_i[x]),
            .pl_data_o  (pl_data[x*8 +: 8]),
            .pl_valid_o (pl_valid[x]),
            .pl_last_o  (pl_last[x])
        );

        tx_frame_fifo #(
            .FIFO_AW (FIFO_AW)
        ) fifo_inst (
            .clk125M       (clk125M),
            .rst_n_i       (rst_n_i),
            .flush_i       (flush[x]),
            .wr_en_i       (wr_en[x]),
            .wr_data_i     (wr_data),
            .wr_last_i     (wr_last),
            .rd_en_i       (rd_en[x]),
            .rd_data_o     (rd_data[x*8 +: 8]),
            .rd_last_o     (rd_last[x]),
            .frame_avail_o (frame_avail[x])
        );

        mac_tx_feeder feeder_inst (
            .clk125M       (clk125M),
            .rst_n_i       (rst_n_i),
            .frame_avail_i (frame_avail[x]),
            .rd_data_i     (rd_data[x*8 +: 8]),
            .rd_last_i     (rd_last[x]),
            .rd_en_o       (rd_en[x]),
            .mac_tx_ack_i  (mac_tx_ack_i[x]),
            .mac_tx_rq_o   (mac_tx_rq_o[x]),
            .mac_tx_data_o (mac_tx_data_o[x*8 +: 8]),
            .mac_tx_val_o  (mac_tx_val_o[x]),
            .mac_tx_sof_o  (mac_tx_sof_o[x]),
            .mac_tx_eof_o  (mac_tx_eof_o[x])
        );
    end

    //------------------------------
    // port selection
    //------------------------------
    port_select #(
        .ETH_COUNT (ETH_COUNT)
    ) select_inst (
        .clk125M           (clk125M),
        .rst_n_i           (rst_n_i),
        .module_en_i       (module_en_i),
        .eth_num_i         (eth_num_i),
        .link_channel_up_i (link_channel_up_i),
        .mac_link_up_i     (mac_link_up_i),
        .pl_data_i         (pl_data),
        .pl_valid_i        (pl_valid),
        .pl_last_i         (pl_last),
        .link_rx_data_i    (link_rx_data_i),
        .link_rx_valid_i   (link_rx_valid_i),
        .link_rx_last_i    (link_rx_last_i),
        .wr_en_o           (wr_en),
        .wr_data_o         (wr_data),
        .wr_last_o         (wr_last),
        .flush_o           (flush),
        .link_tx_data_o    (link_tx_data_o),
        .link_tx_valid_o   (link_tx_valid_o),
        .link_tx_last_o    (link_tx_last_o)
    );

endmodule

`default_nettype wire

//--- testbench/tb_eth_port_bridge.sv
`timescale 1ns/1ps
`default_nettype none
//------------------------------
// ethernet port bridge testbench
// file-driven rx/tx frames, mac grant model, watchdog
//------------------------------
module tb_eth_port_bridge;

    localparam int HDR  = bridge_pkg::HDR_SKIP_BYTES;
    localparam int FCS  = bridge_pkg::FCS_BYTES;
    localparam int MAXF = 32;                   // table size for the stimulus file

    logic        clk125M;
    logic        rst_n_i;
    logic        module_en_i;
    logic        link_channel_up_i;
    logic [1:0]  eth_num_i;
    logic [3:0]  mac_link_up_i;
    logic [31:0] mac_rx_data_i;
    logic [3:0]  mac_rx_den_i;
    logic [3:0]  mac_rx_eof_i;
    logic [3:0]  mac_tx_ack_i;
    logic [3:0]  mac_tx_rq_o;
    logic [31:0] mac_tx_data_o;
    logic [3:0]  mac_tx_val_o;
    logic [3:0]  mac_tx_sof_o;
    logic [3:0]  mac_tx_eof_o;
    logic [7:0]  link_rx_data_i;
    logic        link_rx_valid_i;
    logic        link_rx_last_i;
    logic [7:0]  link_tx_data_o;
    logic        link_tx_valid_o;
    logic        link_tx_last_o;

    // stimulus table with one entry per file line
    byte  f_dir [MAXF];
    int   f_port [MAXF];
    int   f_sel [MAXF];
    int   f_en [MAXF];
    int   f_link [MAXF];
    int   f_chan [MAXF];
    int   f_len [MAXF];
    int   f_first [MAXF];
    int   f_exp [MAXF];

    int          n_frames;
    int          limit_cycles;
    int          errors;
    int          tests_ok;
    int          tests_bad;
    int          cyc;
    int          eof_seen;
    int          rq_rise [4];
    int          ack_wait [4];
    logic [3:0]  rq_prev;
    logic        link_busy;                     // link frame still being driven
    logic [16:0] gap_lfsr;
    logic [16:0] ack_lfsr;
    logic [8:0]  ltx_q [$];                     // {last, data}
    int          mtx_q [$];                     // {cycle, port, sof, eof, data}

    eth_port_bridge #(
        .ETH_COUNT (4),
        .FIFO_AW   (6)
    ) eth_port_bridge_inst (
        .clk125M (clk125M), .rst_n_i (rst_n_i),
        .module_en_i (module_en_i), .eth_num_i (eth_num_i),
        .link_channel_up_i (link_channel_up_i), .mac_link_up_i (mac_link_up_i),
        .mac_rx_data_i (mac_rx_data_i), .mac_rx_den_i (mac_rx_den_i),
        .mac_rx_eof_i (mac_rx_eof_i), .mac_tx_ack_i (mac_tx_ack_i),
        .mac_tx_rq_o (mac_tx_rq_o), .mac_tx_data_o (mac_tx_data_o),
        .mac_tx_val_o (mac_tx_val_o), .mac_tx_sof_o (mac_tx_sof_o),
        .mac_tx_eof_o (mac_tx_eof_o), .link_rx_data_i (link_rx_data_i),
        .link_rx_valid_i (link_rx_valid_i), .link_rx_last_i (link_rx_last_i),
        .link_tx_data_o (link_tx_data_o), .link_tx_valid_o (link_tx_valid_o),
        .link_tx_last_o (link_tx_last_o)
    );

    initial begin
        clk125M = 1'b0;
        forever #4 clk125M = ~clk125M;          // 125 MHz
    end

    // fibonacci lfsr on x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] e, input logic [31:0] a);
        $display("[ERROR] %0t ns %s expected %0h got %0h", $time, name, e, a);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("failure at %0t ns: %s", $time, what);
        errors++;
    endtask

    task automatic load_stimulus;
        int    fd;
        int    code;
        string line;
        string dir_s;
        fd = $fopen("testbench/stimulus_frames.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open testbench/stimulus_frames.txt");
        end else begin
            while (!$feof(fd) && n_frames < MAXF) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line[0] != "#") begin
                    code = $sscanf(line, "%s %d %d %d %d %d %d %h %d", dir_s,
                                   f_port[n_frames], f_sel[n_frames], f_en[n_frames],
                                   f_link[n_frames], f_chan[n_frames], f_len[n_frames],
                                   f_first[n_frames], f_exp[n_frames]);
                    if (code == 9) begin
                        f_dir[n_frames] = dir_s[0];
                        n_frames++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic idle_gap;                    // 1..4 idle cycles
        int g;
        g = 0;
        repeat (2) begin
            gap_lfsr = lfsr_next(gap_lfsr);
            g = (g << 1) | gap_lfsr[0];
        end
        repeat (g + 1) @(posedge clk125M);
        #1;
    endtask

    task automatic drive_mac_frame(input int port, input int len, input int first);
        for (int i = 0; i < len; i++) begin
            mac_rx_data_i[port*8 +: 8] = 8'(first + i);
            mac_rx_den_i[port] = 1'b1;
            mac_rx_eof_i[port] = (i == len - 1);
            @(posedge clk125M);
            #1;
        end
        mac_rx_den_i[port] = 1'b0;
        mac_rx_eof_i[port] = 1'b0;
    endtask

    task automatic drive_link_frame(input int len, input int first);
        link_busy = 1'b1;
        for (int i = 0; i < len; i++) begin
            link_rx_data_i  = 8'(first + i);
            link_rx_valid_i = 1'b1;
            link_rx_last_i  = (i == len - 1);
            @(posedge clk125M);
            #1;
        end
        link_rx_valid_i = 1'b0;
        link_rx_last_i  = 1'b0;
        link_busy       = 1'b0;
    endtask

    //------------------------------
    // output monitors sampled mid-cycle
    //------------------------------
    always @(negedge clk125M) begin
        cyc++;
        if (link_tx_valid_o) begin
            ltx_q.push_back({link_tx_last_o, link_tx_data_o});
        end
        for (int p = 0; p < 4; p++) begin
            if (mac_tx_val_o[p]) begin
                mtx_q.push_back((cyc << 12) | (p << 10) | (mac_tx_sof_o[p] << 9) |
                                (mac_tx_eof_o[p] << 8) | mac_tx_data_o[p*8 +: 8]);
            end
            if (mac_tx_eof_o[p]) begin
                eof_seen++;
            end
            if (mac_tx_rq_o[p] && !rq_prev[p]) begin
                rq_rise[p]++;
                if (link_busy) begin
                    report_failure($sformatf("mac_tx_rq_o[%0d] rose before frame end", p));
                end
            end
        end
        rq_prev = mac_tx_rq_o;
    end

    // mac grant model raises ack 0..7 cycles after rq
    always @(posedge clk125M) begin
        #1;
        for (int p = 0; p < 4; p++) begin
            if (!mac_tx_rq_o[p]) begin
                mac_tx_ack_i[p] = 1'b0;
                ack_wait[p] = 0;
                repeat (3) begin
                    ack_lfsr = lfsr_next(ack_lfsr);
                    ack_wait[p] = (ack_wait[p] << 1) | ack_lfsr[0];
                end
            end else if (!mac_tx_ack_i[p]) begin
                if (ack_wait[p] == 0) begin
                    mac_tx_ack_i[p] = 1'b1;
                end else begin
                    ack_wait[p]--;
                end
            end
        end
    end

    task automatic run_frame(input int t);
        int err0;
        int w;
        int e;
        int exp_rise;
        err0 = errors;
        ltx_q.delete();
        mtx_q.delete();
        eof_seen = 0;
        for (int p = 0; p < 4; p++) begin
            rq_rise[p] = 0;
        end
        eth_num_i         = 2'(f_sel[t]);
        module_en_i       = f_en[t][0];
        link_channel_up_i = f_chan[t][0];
        mac_link_up_i     = 4'hf;
        mac_link_up_i[f_port[t]] = f_link[t][0];    // only the target port's link changes
        @(posedge clk125M);
        #1;
        if (f_dir[t] == "R") begin
            drive_mac_frame(f_port[t], f_len[t], f_first[t]);
            repeat (FCS + 4) @(posedge clk125M);
            #1;
            if (ltx_q.size() != f_exp[t]) begin
                report_mismatch("link_tx_valid_o count", f_exp[t], ltx_q.size());
            end
            for (int i = 0; i < ltx_q.size(); i++) begin
                if (ltx_q[i][7:0] !== 8'(f_first[t] + HDR + i)) begin
                    report_mismatch("link_tx_data_o", 8'(f_first[t] + HDR + i), ltx_q[i][7:0]);
                end
                if (ltx_q[i][8] !== (i == f_exp[t] - 1)) begin
                    report_mismatch("link_tx_last_o", (i == f_exp[t] - 1), ltx_q[i][8]);
                end
            end
        end else begin
            drive_link_frame(f_len[t], f_first[t]);
            if (f_exp[t] > 0) begin
                for (w = 0; w < 8 * f_len[t] + 64 && eof_seen == 0; w++) begin
                    @(posedge clk125M);
                end
                #1;
                if (eof_seen == 0) begin
                    report_failure("the frame never ended on mac_tx_eof_o");
                end
                if (mac_tx_rq_o[f_port[t]]) begin
                    report_failure("mac_tx_rq_o stayed high after the frame");
                end
            end else begin
                repeat (32) @(posedge clk125M);
                #1;
            end
            for (int p = 0; p < 4; p++) begin
                exp_rise = (p == f_port[t] && f_exp[t] > 0);
                if (rq_rise[p] != exp_rise) begin
                    report_mismatch($sformatf("mac_tx_rq_o[%0d] rises", p), exp_rise, rq_rise[p]);
                end
            end
            if (mtx_q.size() != f_exp[t]) begin
                report_mismatch("mac_tx_val_o count", f_exp[t], mtx_q.size());
            end
            for (int i = 0; i < mtx_q.size(); i++) begin
                e = mtx_q[i];
                if (((e >> 10) & 3) != f_port[t]) begin
                    report_mismatch("mac_tx_val_o port", f_port[t], (e >> 10) & 3);
                end
                if ((e & 8'hff) != ((f_first[t] + i) & 8'hff)) begin
                    report_mismatch("mac_tx_data_o", (f_first[t] + i) & 8'hff, e & 8'hff);
                end
                if (((e >> 9) & 1) != (i == 0)) begin
                    report_mismatch("mac_tx_sof_o", (i == 0), (e >> 9) & 1);
                end
                if (((e >> 8) & 1) != (i == f_exp[t] - 1)) begin
                    report_mismatch("mac_tx_eof_o", (i == f_exp[t] - 1), (e >> 8) & 1);
                end
                if ((e >> 12) != (mtx_q[0] >> 12) + i) begin
                    report_failure("mac_tx_val_o has a gap inside the frame");
                end
            end
        end
        idle_gap();
        if (errors == err0) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        $display("test %0d %c port %0d len %0d: %s", t + 1, f_dir[t], f_port[t], f_len[t],
                 (errors == err0) ? "ok" : "FAILED");
    endtask

    //------------------------------
    // main sequence
    //------------------------------
    initial begin
        int total;
        rst_n_i = 1'b0;
        module_en_i = 1'b0;
        link_channel_up_i = 1'b0;
        eth_num_i = '0;
        mac_link_up_i = '0;
        mac_rx_data_i = '0;
        mac_rx_den_i = '0;
        mac_rx_eof_i = '0;
        mac_tx_ack_i = '0;
        link_rx_data_i = '0;
        link_rx_valid_i = 1'b0;
        link_rx_last_i = 1'b0;
        link_busy = 1'b0;
        rq_prev = '0;
        gap_lfsr = 17'd95063;
        ack_lfsr = 17'd95063;
        load_stimulus();
        if (n_frames == 0) begin
            report_failure("the stimulus file holds no frames");
        end
        total = 0;
        for (int t = 0; t < n_frames; t++) begin
            total += f_len[t];
        end
        limit_cycles = total * 40 + 2000;
        repeat (3) @(posedge clk125M);
        #1 rst_n_i = 1'b1;
        repeat (2) @(posedge clk125M);
        #1;
        // idle outputs after reset
        if (mac_tx_rq_o !== 4'h0) report_mismatch("mac_tx_rq_o", 0, mac_tx_rq_o);
        if (mac_tx_val_o !== 4'h0) report_mismatch("mac_tx_val_o", 0, mac_tx_val_o);
        if (mac_tx_sof_o !== 4'h0) report_mismatch("mac_tx_sof_o", 0, mac_tx_sof_o);
        if (mac_tx_eof_o !== 4'h0) report_mismatch("mac_tx_eof_o", 0, mac_tx_eof_o);
        if (link_tx_valid_o !== 1'b0) report_mismatch("link_tx_valid_o", 0, link_tx_valid_o);
        $display("test 0 reset outputs: %s", (errors == 0) ? "ok" : "FAILED");
        if (errors == 0) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        for (int t = 0; t < n_frames; t++) begin
            run_frame(t);
        end
        $display("tests: %0d passed, %0d failed, %0d errors", tests_ok, tests_bad, errors);
        if (tests_bad == 0 && errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog sized from the total frame bytes
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk125M);
        $display("timeout: run did not finish within %0d cycles", limit_cycles);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/stimulus_frames.txt
# dir(R mac rx, T link rx) port sel module_en link_up channel_up len first_byte(hex) expected
# R expects len-12 bytes on link tx when selected, T expects len bytes on the port's mac tx
R 0 0 1 1 1 20 10 8
R 2 2 1 1 1 30 a0 18
R 1 2 1 1 1 20 00 0
R 3 3 0 1 1 20 00 0
R 1 1 1 1 1 12 40 0
R 1 1 1 1 1 13 50 1
R 3 3 1 1 1 64 f0 52
T 0 0 1 1 1 16 20 16
T 3 3 1 1 1 40 e0 40
T 1 1 1 0 1 10 00 0
T 2 2 1 1 0 10 00 0
T 2 2 0 1 1 10 00 0
T 1 1 1 1 1 1 33 1
T 2 2 1 1 1 48 80 48
R 0 0 1 1 1 14 ff 2

//--- eth_port_bridge.f
design/bridge_pkg.sv
design/rx_payload_strip.sv
design/tx_frame_fifo.sv
design/mac_tx_feeder.sv
design/port_select.sv
design/eth_port_bridge.sv
testbench/tb_eth_port_bridge.sv
